/* common/obj_pkg.sv */
package obj_pkg;

    // Sprite RAM entry geometry
    localparam int entry_words = 8;

    typedef logic [15:0] entry_word_t;
    typedef logic [14:0] ram_addr_t;
    typedef logic [11:0] coord_t;
    typedef logic [13:0] tile_code_t;

    // Visible area and sequence step
    localparam coord_t x_limit  = 12'd400;
    localparam coord_t y_limit  = 12'd240;
    localparam coord_t seq_step = 12'd16;

    // Word numbers inside an entry
    localparam int word_tile = 0;
    localparam int word_attr = 4;
    localparam int word_x    = 6;
    localparam int word_y    = 7;

    // Word 4, colour and sequence control
    localparam int w4_color_lsb  = 0;
    localparam int w4_x_flip_bit = 8;
    localparam int w4_y_flip_bit = 9;
    localparam int w4_cont_y_bit = 12;
    localparam int w4_inc_y_bit  = 13;
    localparam int w4_cont_x_bit = 14;
    localparam int w4_inc_x_bit  = 15;

    // Word 6, scroll control bits above the x coordinate
    localparam int w6_latch_extra_bit  = 12;
    localparam int w6_latch_master_bit = 13;
    localparam int w6_no_extra_bit     = 14;
    localparam int w6_absolute_bit     = 15;

    // Draw descriptor data word
    localparam int desc_tile_lsb   = 0;
    localparam int desc_color_lsb  = 14;
    localparam int desc_x_flip_bit = 22;
    localparam int desc_y_flip_bit = 23;

    // Framebuffer block address offset
    localparam int addr_x_lsb  = 3;
    localparam int addr_y_lsb  = 10;
    localparam int addr_buf_bit = 18;

    typedef enum logic [2:0] {
        IDLE,
        READ,
        EVAL,
        BOUNDS,
        EMIT,
        WAIT_RESP
    } obj_state_t;

endpackage

/* source/entry_fetch.sv */
`timescale 1ns/1ps

module entry_fetch (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fetch_start,
    input  logic [9:0]           entry_index,
    input  obj_pkg::entry_word_t ram_rdata,
    output logic                 ram_cs,
    output obj_pkg::ram_addr_t   ram_addr,
    output logic                 fetch_done,
    output obj_pkg::tile_code_t  tile_code,
    output logic [7:0]           color,
    output logic                 x_flip,
    output logic                 y_flip,
    output obj_pkg::entry_word_t entry_word_4,
    output obj_pkg::entry_word_t entry_word_6,
    output obj_pkg::entry_word_t entry_word_7
);
    import obj_pkg::*;

    localparam int word_bits = $clog2(entry_words);

    logic                 issuing;
    logic [word_bits-1:0] issue_word;
    logic                 cap_en;
    logic [word_bits-1:0] cap_word;
    entry_word_t          work_buffer [entry_words];

    // Word counter rests at 0, so word 0 goes out with fetch_start
    assign ram_cs   = fetch_start | issuing;
    assign ram_addr = ram_addr_t'({entry_index, issue_word});

    always_ff @(posedge clk) begin
        if (rst) begin
            issuing    <= 1'b0;
            issue_word <= '0;
            cap_en     <= 1'b0;
            fetch_done <= 1'b0;
        end else begin
            cap_en     <= ram_cs;
            fetch_done <= ram_cs && (issue_word == word_bits'(entry_words - 1));
            if (ram_cs) begin
                issue_word <= issue_word + 1'b1;
                issuing    <= (issue_word != word_bits'(entry_words - 1));
            end
        end
    end

    // Read data arrives one cycle behind its address
    always_ff @(posedge clk) begin
        cap_word <= issue_word;
        if (cap_en) begin
            work_buffer[cap_word] <= ram_rdata;
        end
    end

    assign tile_code    = tile_code_t'(work_buffer[word_tile]);
    assign color        = work_buffer[word_attr][w4_color_lsb +: 8];
    assign x_flip       = work_buffer[word_attr][w4_x_flip_bit];
    assign y_flip       = work_buffer[word_attr][w4_y_flip_bit];
    assign entry_word_4 = work_buffer[word_attr];
    assign entry_word_6 = work_buffer[word_x];
    assign entry_word_7 = work_buffer[word_y];

endmodule

/* source/position_calc.sv */
`timescale 1ns/1ps

module position_calc (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 eval,
    input  obj_pkg::tile_code_t  tile_code,
    input  obj_pkg::entry_word_t entry_word_4,
    input  obj_pkg::entry_word_t entry_word_6,
    input  obj_pkg::entry_word_t entry_word_7,
    output logic                 visible,
    output obj_pkg::coord_t      draw_x,
    output obj_pkg::coord_t      draw_y
);
    import obj_pkg::*;

    coord_t master_x;
    coord_t master_y;
    coord_t extra_x;
    coord_t extra_y;
    coord_t scroll_x;
    coord_t scroll_y;
    coord_t base_x;
    coord_t base_y;
    coord_t next_x;
    coord_t next_y;

    always_comb begin
        scroll_x = '0;
        scroll_y = '0;
        // Absolute entries ignore both scroll latches
        if (!entry_word_6[w6_absolute_bit]) begin
            scroll_x = master_x;
            scroll_y = master_y;
            if (!entry_word_6[w6_no_extra_bit]) begin
                scroll_x = master_x + extra_x;
                scroll_y = master_y + extra_y;
            end
        end
        base_x = coord_t'(entry_word_6) + scroll_x;
        base_y = coord_t'(entry_word_7) + scroll_y;

        // Sequence entries continue from the last draw position
        next_x = entry_word_4[w4_cont_x_bit] ? draw_x : base_x;
        next_y = entry_word_4[w4_cont_y_bit] ? draw_y : base_y;
        if (entry_word_4[w4_inc_x_bit]) begin
            next_x = next_x + seq_step;
        end
        if (entry_word_4[w4_inc_y_bit]) begin
            next_y = next_y + seq_step;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            master_x <= '0;
            master_y <= '0;
            extra_x  <= '0;
            extra_y  <= '0;
            draw_x   <= '0;
            draw_y   <= '0;
            visible  <= 1'b0;
        end else if (eval) begin
            if (entry_word_6[w6_latch_master_bit]) begin
                master_x <= base_x;
                master_y <= base_y;
            end
            if (entry_word_6[w6_latch_extra_bit]) begin
                extra_x <= base_x;
                extra_y <= base_y;
            end
            draw_x  <= next_x;
            draw_y  <= next_y;
            // Negative coordinates wrap high and fall outside too
            visible <= (tile_code != '0) && (next_x <= x_limit) && (next_y <= y_limit);
        end
    end

endmodule

/* source/draw_emitter.sv */
`timescale 1ns/1ps

module draw_emitter #(
    parameter logic [31:0] fb_base = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                emit,
    input  logic                draw_buffer,
    input  obj_pkg::coord_t     draw_x,
    input  obj_pkg::coord_t     draw_y,
    input  obj_pkg::tile_code_t tile_code,
    input  logic [7:0]          color,
    input  logic                x_flip,
    input  logic                y_flip,
    input  logic                awready,
    input  logic                wready,
    input  logic                bvalid,
    output logic [31:0]         awaddr,
    output logic                awvalid,
    output logic [31:0]         wdata,
    output logic [3:0]          wstrb,
    output logic                wvalid,
    output logic                bready,
    output logic                emit_done
);
    import obj_pkg::*;

    logic [31:0] desc_offset;
    logic [31:0] desc_data;
    logic        in_flight;
    logic        aw_left;
    logic        w_left;

    always_comb begin
        desc_offset = '0;
        desc_offset[addr_x_lsb +: 7] = draw_x[8:2];
        desc_offset[addr_y_lsb +: 8] = draw_y[7:0];
        desc_offset[addr_buf_bit]    = draw_buffer;

        desc_data = '0;
        desc_data[desc_tile_lsb +: 14] = tile_code;
        desc_data[desc_color_lsb +: 8] = color;
        desc_data[desc_x_flip_bit]     = x_flip;
        desc_data[desc_y_flip_bit]     = y_flip;
    end

    // Channel still waiting after this cycle
    assign aw_left = awvalid && !awready;
    assign w_left  = wvalid && !wready;

    assign wstrb = 4'hf;

    always_ff @(posedge clk) begin
        if (emit) begin
            awaddr <= fb_base + desc_offset;
            wdata  <= desc_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= 1'b0;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            bready    <= 1'b0;
            emit_done <= 1'b0;
        end else begin
            emit_done <= 1'b0;
            if (emit) begin
                in_flight <= 1'b1;
                awvalid   <= 1'b1;
                wvalid    <= 1'b1;
            end else if (in_flight) begin
                // AW and W complete independently
                awvalid <= aw_left;
                wvalid  <= w_left;
                if (!bready && !aw_left && !w_left) begin
                    bready <= 1'b1;
                end
                if (bready && bvalid) begin
                    bready    <= 1'b0;
                    in_flight <= 1'b0;
                    emit_done <= 1'b1;
                end
            end
        end
    end

endmodule

/* source/obj_sequencer.sv */
`timescale 1ns/1ps

module obj_sequencer #(
    parameter int unsigned max_entries = 835
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       vbl_n,
    input  logic       fetch_done,
    input  logic       visible,
    input  logic       emit_done,
    output logic       busy,
    output logic       fetch_start,
    output logic [9:0] entry_index,
    output logic       eval,
    output logic       emit,
    output logic       draw_buffer
);
    import obj_pkg::*;

    obj_state_t state;
    logic       prev_vbl_n;
    logic       vbl_pend;
    logic       vbl_edge;
    logic       vbl_seen;
    logic       last_entry;
    logic       entry_end;

    // Falling blank edge, remembered until the walker can act on it
    assign vbl_edge = prev_vbl_n & ~vbl_n;
    assign vbl_seen = vbl_edge | vbl_pend;

    assign last_entry = (entry_index == 10'(max_entries - 1));

    // Entry finished without drawing, or its descriptor was acknowledged
    assign entry_end = ((state == BOUNDS) && !vbl_seen && !visible) ||
                       ((state == WAIT_RESP) && emit_done);

    assign eval = (state == EVAL);
    assign emit = (state == EMIT);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            busy        <= 1'b0;
            fetch_start <= 1'b0;
            entry_index <= '0;
            draw_buffer <= 1'b0;
            prev_vbl_n  <= 1'b1;
            vbl_pend    <= 1'b0;
        end else begin
            prev_vbl_n  <= vbl_n;
            fetch_start <= 1'b0;
            if (vbl_edge) begin
                vbl_pend <= 1'b1;
            end

            case (state)
                IDLE: begin
                    if (vbl_seen) begin
                        vbl_pend    <= 1'b0;
                        busy        <= 1'b1;
                        draw_buffer <= ~draw_buffer;
                        entry_index <= '0;
                        fetch_start <= 1'b1;
                        state       <= READ;
                    end
                end

                READ: begin
                    if (fetch_done) begin
                        state <= EVAL;
                    end
                end

                EVAL: state <= BOUNDS;

                BOUNDS: begin
                    // A new blank abandons the frame; IDLE then starts the next one
                    if (vbl_seen) begin
                        busy  <= 1'b0;
                        state <= IDLE;
                    end else if (visible) begin
                        state <= EMIT;
                    end
                end

                EMIT: state <= WAIT_RESP;

                WAIT_RESP: ;

                default: state <= IDLE;
            endcase

            // Move on to the next entry or close the frame
            if (entry_end) begin
                if (last_entry) begin
                    busy  <= 1'b0;
                    state <= IDLE;
                end else begin
                    entry_index <= entry_index + 10'd1;
                    fetch_start <= 1'b1;
                    state       <= READ;
                end
            end
        end
    end

endmodule

/* source/obj_top.sv */
`timescale 1ns/1ps

module obj_top #(
    parameter int unsigned max_entries = 835,
    parameter logic [31:0] fb_base     = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 vbl_n,
    input  obj_pkg::entry_word_t ram_rdata,
    input  logic                 awready,
    input  logic                 wready,
    input  logic                 bvalid,
    input  logic [1:0]           bresp,
    output logic                 busy,
    output logic                 ram_cs,
    output obj_pkg::ram_addr_t   ram_addr,
    output logic [31:0]          awaddr,
    output logic                 awvalid,
    output logic [31:0]          wdata,
    output logic [3:0]           wstrb,
    output logic                 wvalid,
    output logic                 bready
);
    import obj_pkg::*;

    // Sequencer handshakes
    logic       fetch_start;
    logic       fetch_done;
    logic [9:0] entry_index;
    logic       eval;
    logic       emit;
    logic       emit_done;
    logic       draw_buffer;

    // Entry fields from the work buffer
    tile_code_t  tile_code;
    logic [7:0]  color;
    logic        x_flip;
    logic        y_flip;
    entry_word_t entry_word_4;
    entry_word_t entry_word_6;
    entry_word_t entry_word_7;

    // Evaluated position
    logic   visible;
    coord_t draw_x;
    coord_t draw_y;

    obj_sequencer #(
        .max_entries(max_entries)
    ) obj_sequencer_inst (
        .clk        (clk),
        .rst        (rst),
        .vbl_n      (vbl_n),
        .fetch_done (fetch_done),
        .visible    (visible),
        .emit_done  (emit_done),
        .busy       (busy),
        .fetch_start(fetch_start),
        .entry_index(entry_index),
        .eval       (eval),
        .emit       (emit),
        .draw_buffer(draw_buffer)
    );

    entry_fetch entry_fetch_inst (
        .clk         (clk),
        .rst         (rst),
        .fetch_start (fetch_start),
        .entry_index (entry_index),
        .ram_rdata   (ram_rdata),
        .ram_cs      (ram_cs),
        .ram_addr    (ram_addr),
        .fetch_done  (fetch_done),
        .tile_code   (tile_code),
        .color       (color),
        .x_flip      (x_flip),
        .y_flip      (y_flip),
        .entry_word_4(entry_word_4),
        .entry_word_6(entry_word_6),
        .entry_word_7(entry_word_7)
    );

    position_calc position_calc_inst (
        .clk         (clk),
        .rst         (rst),
        .eval        (eval),
        .tile_code   (tile_code),
        .entry_word_4(entry_word_4),
        .entry_word_6(entry_word_6),
        .entry_word_7(entry_word_7),
        .visible     (visible),
        .draw_x      (draw_x),
        .draw_y      (draw_y)
    );

    // bresp is not checked, every response completes the descriptor
    draw_emitter #(
        .fb_base(fb_base)
    ) draw_emitter_inst (
        .clk        (clk),
        .rst        (rst),
        .emit       (emit),
        .draw_buffer(draw_buffer),
        .draw_x     (draw_x),
        .draw_y     (draw_y),
        .tile_code  (tile_code),
        .color      (color),
        .x_flip     (x_flip),
        .y_flip     (y_flip),
        .awready    (awready),
        .wready     (wready),
        .bvalid     (bvalid),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .bready     (bready),
        .emit_done  (emit_done)
    );

endmodule

/* tb/obj_properties.sv */
`timescale 1ns/1ps

module obj_properties (
    input logic        clk,
    input logic        rst,
    input logic [31:0] awaddr,
    input logic        awvalid,
    input logic        awready,
    input logic [31:0] wdata,
    input logic        wvalid,
    input logic        wready,
    input logic        bready
);

    // Address and data hold until accepted
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid or awaddr changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else $error("wvalid or wdata changed before wready");

    no_valid_in_reset: assert property (@(posedge clk)
        rst |=> !awvalid && !wvalid && !bready)
        else $error("valid or bready high during reset");

    // Response is only accepted once both channels are done
    bready_after_aw_w: assert property (@(posedge clk) disable iff (rst)
        $rose(bready) |-> !awvalid && !wvalid)
        else $error("bready rose with AW or W still pending");

endmodule

bind draw_emitter obj_properties obj_properties_inst (
    .clk    (clk),
    .rst    (rst),
    .awaddr (awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata  (wdata),
    .wvalid (wvalid),
    .wready (wready),
    .bready (bready)
);

/* tb/obj_checker.sv */
`timescale 1ns/1ps

module obj_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        busy,
    input  logic        ram_cs,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    input  logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    input  logic        wready,
    input  logic        bready,
    input  logic        frame_end,
    input  int          frame_num,
    input  logic [31:0] exp_addr [8],
    input  logic [31:0] exp_data [8],
    input  int          exp_count,
    output int          error_count,
    output int          tests_run,
    output int          tests_failed
);

    int          got;
    int          frame_errors;
    logic        have_aw;
    logic        have_w;
    logic [31:0] aw_seen;
    logic [31:0] w_seen;
    logic        rst_d;

    initial begin
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        got          = 0;
        frame_errors = 0;
        have_aw      = 1'b0;
        have_w       = 1'b0;
        rst_d        <= 1'b1;
    end

    task automatic note_error();
        error_count  = error_count + 1;
        frame_errors = frame_errors + 1;
    endtask

    always @(posedge clk) begin
        rst_d <= rst;
        if (!rst) begin
            // Idle outputs right after reset
            if (rst_d) begin
                tests_run = tests_run + 1;
                if (busy || ram_cs || awvalid || wvalid || bready) begin
                    error_count  = error_count + 1;
                    tests_failed = tests_failed + 1;
                    $display("after reset: busy, ram_cs or an AXI valid is not low");
                end else begin
                    $display("after reset: ok");
                end
            end

            if (awvalid && awready) begin
                aw_seen = awaddr;
                have_aw = 1'b1;
            end
            if (wvalid && wready) begin
                w_seen = wdata;
                have_w = 1'b1;
                // Full word writes only
                if (wstrb !== 4'hf) begin
                    note_error();
                    $display("[ERROR] frame %0d desc %0d wstrb: got %h expected %h",
                             frame_num, got, wstrb, 4'hf);
                end
            end

            if (have_aw && have_w) begin
                if (got >= exp_count) begin
                    note_error();
                    $display("frame %0d: extra write to %h beyond the %0d expected",
                             frame_num, aw_seen, exp_count);
                end else begin
                    if (aw_seen !== exp_addr[got]) begin
                        note_error();
                        $display("[ERROR] frame %0d desc %0d awaddr: got %h expected %h",
                                 frame_num, got, aw_seen, exp_addr[got]);
                    end
                    if (w_seen !== exp_data[got]) begin
                        note_error();
                        $display("[ERROR] frame %0d desc %0d wdata: got %h expected %h",
                                 frame_num, got, w_seen, exp_data[got]);
                    end
                end
                got     = got + 1;
                have_aw = 1'b0;
                have_w  = 1'b0;
            end

            if (frame_end) begin
                if (got < exp_count) begin
                    note_error();
                    $display("frame %0d: only %0d of %0d descriptors were written",
                             frame_num, got, exp_count);
                end
                if (awvalid || wvalid || bready || have_aw || have_w) begin
                    note_error();
                    $display("frame %0d: a write was still outstanding when busy fell",
                             frame_num);
                end
                tests_run = tests_run + 1;
                if (frame_errors != 0) begin
                    tests_failed = tests_failed + 1;
                end
                $display("frame %0d: %s, %0d descriptors", frame_num,
                         (frame_errors == 0) ? "ok" : "failed", got);
                got          = 0;
                frame_errors = 0;
            end
        end
    end

endmodule

/* tb/tb_obj_top.sv */
`timescale 1ns/1ps

module tb_obj_top;
    import obj_pkg::*;

    localparam int n_frames   = 4;
    localparam int n_entries  = 16;
    localparam int timeout_ns = n_frames * n_entries * 40 * 4 + 200;
    localparam int pool_size  = 256;

    logic        clk;
    logic        rst;
    logic        vbl_n;
    entry_word_t ram_rdata;
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic        busy;
    logic        ram_cs;
    ram_addr_t   ram_addr;
    logic [31:0] awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        bready;

    // Stimulus table, one row per frame
    logic [15:0] w0_tab [n_frames][n_entries];
    logic [15:0] w4_tab [n_frames][n_entries];
    logic [15:0] w6_tab [n_frames][n_entries];
    logic [15:0] w7_tab [n_frames][n_entries];
    logic [31:0] addr_tab [n_frames][8];
    logic [31:0] data_tab [n_frames][8];
    int          count_tab [n_frames];

    // Row currently handed to the checker
    logic [31:0] cur_addr [8];
    logic [31:0] cur_data [8];
    int          cur_count;
    int          frame_num;
    logic        frame_end;

    entry_word_t mem [128];
    int          aw_delay;
    int          w_delay;
    int          b_delay;
    int          delay_pool [pool_size];
    int          pool_idx;
    int          error_count;
    int          tests_run;
    int          tests_failed;

    obj_top #(
        .max_entries(n_entries),
        .fb_base    (32'h0000_0000)
    ) obj_top_inst (
        .clk      (clk),
        .rst      (rst),
        .vbl_n    (vbl_n),
        .ram_rdata(ram_rdata),
        .awready  (awready),
        .wready   (wready),
        .bvalid   (bvalid),
        .bresp    (2'b00),
        .busy     (busy),
        .ram_cs   (ram_cs),
        .ram_addr (ram_addr),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .bready   (bready)
    );

    obj_checker obj_checker_inst (
        .clk         (clk),
        .rst         (rst),
        .busy        (busy),
        .ram_cs      (ram_cs),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bready      (bready),
        .frame_end   (frame_end),
        .frame_num   (frame_num),
        .exp_addr    (cur_addr),
        .exp_data    (cur_data),
        .exp_count   (cur_count),
        .error_count (error_count),
        .tests_run   (tests_run),
        .tests_failed(tests_failed)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Delays are drawn up front in the seeded process
    function automatic int next_delay();
        int d;
        d = delay_pool[pool_idx];
        pool_idx = (pool_idx + 1) % pool_size;
        return d;
    endfunction

    // Sprite RAM, one cycle of read latency
    always @(posedge clk) begin
        ram_rdata <= mem[ram_addr[6:0]];
    end

    // AXI slave with random ready and response delays
    always @(negedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (awready) begin
                awready  <= 1'b0;
                aw_delay = next_delay();
            end else if (awvalid) begin
                if (aw_delay == 0) awready <= 1'b1;
                else aw_delay = aw_delay - 1;
            end
            if (wready) begin
                wready  <= 1'b0;
                w_delay = next_delay();
            end else if (wvalid) begin
                if (w_delay == 0) wready <= 1'b1;
                else w_delay = w_delay - 1;
            end
            if (bvalid) begin
                bvalid  <= 1'b0;
                b_delay = next_delay();
            end else if (bready) begin
                if (b_delay == 0) bvalid <= 1'b1;
                else b_delay = b_delay - 1;
            end
        end
    end

    task automatic set_entry(input int f, input int e, input logic [15:0] w0,
                             input logic [15:0] w4, input logic [15:0] w6,
                             input logic [15:0] w7);
        w0_tab[f][e] = w0;
        w4_tab[f][e] = w4;
        w6_tab[f][e] = w6;
        w7_tab[f][e] = w7;
    endtask

    task automatic set_desc(input int f, input logic [31:0] addr, input logic [31:0] data);
        addr_tab[f][count_tab[f]] = addr;
        data_tab[f][count_tab[f]] = data;
        count_tab[f] = count_tab[f] + 1;
    endtask

    task automatic build_table();
        for (int f = 0; f < n_frames; f++) begin
            count_tab[f] = 0;
            for (int e = 0; e < n_entries; e++) begin
                set_entry(f, e, 16'h0, 16'h0, 16'h0, 16'h0);
            end
        end
        // Absolute sprites and bounds, buffer 1; frame 3 repeats it on buffer 0
        for (int f = 0; f < n_frames; f += 3) begin
            set_entry(f, 0, 16'h0123, 16'h0145, 16'h8064, 16'h0032);
            set_entry(f, 1, 16'h0000, 16'h0000, 16'h800A, 16'h000A);
            set_entry(f, 2, 16'h0200, 16'h0207, 16'h8191, 16'h0010);
            set_entry(f, 3, 16'h0300, 16'h0000, 16'h8190, 16'h00F1);
            set_entry(f, 4, 16'h3FFF, 16'h03FF, 16'h8190, 16'h00F0);
            set_entry(f, 5, 16'h0001, 16'h0000, 16'h8000, 16'h0000);
            set_desc(f, (f == 0) ? 32'h0004_C8C8 : 32'h0000_C8C8, 32'h0051_4123);
            set_desc(f, (f == 0) ? 32'h0007_C320 : 32'h0003_C320, 32'h00FF_FFFF);
            set_desc(f, (f == 0) ? 32'h0004_0000 : 32'h0000_0000, 32'h0000_0001);
        end
        // Master latch (20,8) and extra latch (4,4) by tile-0 entries
        set_entry(1, 0, 16'h0000, 16'h0000, 16'hA014, 16'h0008);
        set_entry(1, 1, 16'h0000, 16'h0000, 16'h9004, 16'h0004);
        set_entry(1, 2, 16'h0010, 16'h0001, 16'h0064, 16'h003C);
        set_entry(1, 3, 16'h0011, 16'h0002, 16'h4064, 16'h003C);
        set_desc(1, 32'h0001_20F8, 32'h0000_4010);
        set_desc(1, 32'h0001_10F0, 32'h0000_8011);
        // Sequence from (200,100) in steps of 16
        set_entry(2, 0, 16'h0020, 16'h0000, 16'h80C8, 16'h0064);
        set_entry(2, 1, 16'h0021, 16'hD000, 16'h8000, 16'h0000);
        set_entry(2, 2, 16'h0022, 16'h7000, 16'h8000, 16'h0000);
        set_entry(2, 3, 16'h0000, 16'hF000, 16'h8000, 16'h0000);
        set_entry(2, 4, 16'h0023, 16'hD000, 16'h8000, 16'h0000);
        set_desc(2, 32'h0005_9190, 32'h0000_0020);
        set_desc(2, 32'h0005_91B0, 32'h0000_0021);
        set_desc(2, 32'h0005_D1B0, 32'h0000_0022);
        set_desc(2, 32'h0006_11F0, 32'h0000_0023);
    endtask

    task automatic load_frame(input int f);
        for (int a = 0; a < 128; a++) begin
            mem[a] = 16'(a * 16'h0123 + 16'h5A5A);
        end
        for (int e = 0; e < n_entries; e++) begin
            mem[e * entry_words + word_tile] = w0_tab[f][e];
            mem[e * entry_words + word_attr] = w4_tab[f][e];
            mem[e * entry_words + word_x]    = w6_tab[f][e];
            mem[e * entry_words + word_y]    = w7_tab[f][e];
        end
        for (int i = 0; i < 8; i++) begin
            cur_addr[i] = addr_tab[f][i];
            cur_data[i] = data_tab[f][i];
        end
        cur_count = count_tab[f];
        frame_num = f;
    endtask

    initial begin
        void'($urandom(59225));
        for (int i = 0; i < pool_size; i++) begin
            delay_pool[i] = $urandom % 8;
        end
        pool_idx  = 0;
        rst       = 1'b1;
        vbl_n     = 1'b1;
        awready   <= 1'b0;
        wready    <= 1'b0;
        bvalid    <= 1'b0;
        ram_rdata <= '0;
        frame_end = 1'b0;
        aw_delay  = next_delay();
        w_delay   = next_delay();
        b_delay   = next_delay();
        build_table();
        load_frame(0);
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int f = 0; f < n_frames; f++) begin
            load_frame(f);
            repeat (2) @(negedge clk);
            vbl_n = 1'b0;
            while (!busy) @(negedge clk);
            vbl_n = 1'b1;
            while (busy) @(negedge clk);
            frame_end = 1'b1;
            @(negedge clk);
            frame_end = 1'b0;
        end

        repeat (2) @(negedge clk);
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(timeout_ns);
        $display("timeout: frames did not finish within %0d ns", timeout_ns);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* list.f */
common/obj_pkg.sv
source/entry_fetch.sv
source/position_calc.sv
source/draw_emitter.sv
source/obj_sequencer.sv
source/obj_top.sv
tb/obj_properties.sv
tb/obj_checker.sv
tb/tb_obj_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_obj_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qF "*** TEST PASSED ***"

clean:
	rm -rf $(OBJ_DIR)
